/* flist.f */
+incdir+hdl
hdl/cpu_front_pkg.sv
hdl/program_fetch.sv
hdl/fetch_queue.sv
hdl/instr_decode.sv
hdl/micro_sequencer.sv
hdl/cpu_front_top.sv
bench/front_checker.sv
bench/front_assert.sv
bench/tb_cpu_front.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_cpu_front
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

SOURCES := $(filter-out +incdir+%,$(shell cat $(FLIST))) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_cpu_front.sv */
`timescale 1ns/100ps
`include "cpu_front_config.svh"

module tb_cpu_front;
    localparam int PROG_WORDS     = 1 << `PC_WIDTH;
    localparam int REF_ENTRIES    = 24;
    localparam int CLK_HALF       = 50;
    localparam int DRIVE_DELAY    = 10;
    localparam int RESET_CYCLES   = 2;
    localparam int RUN_CYCLES     = 3000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 6;  // Margin over the run

    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0] opcode;
        logic [`UADDR_WIDTH-1:0]  uaddr;
        logic [3:0]               len;       // Clocks per routine
        logic                     skip;
        logic                     illegal;
    } ref_entry_t;

    localparam logic [`UADDR_WIDTH-1:0] ILL = 7'(`ILLEGAL_UADDR);

    localparam ref_entry_t REF_TBL [REF_ENTRIES] = '{
        '{12'h0A5, 7'd0,  4'd5,  1'b0, 1'b0},   // JP s
        '{12'h13C, 7'd1,  4'd12, 1'b1, 1'b0},   // RETD e
        '{12'h2F0, 7'd2,  4'd5,  1'b0, 1'b0},
        '{12'h47E, 7'd4,  4'd7,  1'b1, 1'b0},   // CALL s
        '{12'h512, 7'd5,  4'd7,  1'b1, 1'b0},
        '{12'h8C3, 7'd8,  4'd5,  1'b0, 1'b0},
        '{12'hA07, 7'd10, 4'd7,  1'b0, 1'b0},
        '{12'hA9B, 7'd19, 4'd7,  1'b0, 1'b0},
        '{12'hAF4, 7'd25, 4'd7,  1'b0, 1'b0},
        '{12'hB5A, 7'd26, 4'd5,  1'b0, 1'b0},
        '{12'hC81, 7'd29, 4'd7,  1'b0, 1'b0},
        '{12'hDC4, 7'd34, 4'd7,  1'b0, 1'b0},
        '{12'hE3F, 7'd35, 4'd5,  1'b0, 1'b0},
        '{12'hE9A, 7'd45, 4'd5,  1'b0, 1'b0},
        '{12'hEDB, ILL,   4'd5,  1'b0, 1'b1},   // Gap in the E page
        '{12'hF21, ILL,   4'd5,  1'b0, 1'b1},
        '{12'hF2B, 7'd57, 4'd7,  1'b0, 1'b0},
        '{12'hF63, 7'd63, 4'd7,  1'b0, 1'b0},
        '{12'hFC5, 7'd71, 4'd5,  1'b0, 1'b0},
        '{12'hFDE, 7'd87, 4'd12, 1'b0, 1'b0},   // RETS
        '{12'hFDF, 7'd88, 4'd7,  1'b1, 1'b0},   // RET
        '{12'hFEA, ILL,   4'd5,  1'b0, 1'b1},
        '{12'hFFB, 7'd96, 4'd5,  1'b0, 1'b0},
        '{12'hFFF, 7'd97, 4'd7,  1'b0, 1'b0}
    };

    logic                     clk = 1'b0;
    logic                     arst_n;
    logic                     pc_load;
    logic [`PC_WIDTH-1:0]     pc_load_value;
    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`PC_WIDTH-1:0]     pc;
    logic                     rd;
    cpu_front_pkg::uop_t      uop;

    logic [4:0]           prog_idx [PROG_WORDS];   // Table index per program word
    logic                 rd_q;
    logic [`PC_WIDTH-1:0] rd_addr;
    ref_entry_t           exp_entry;
    int                   error_count;
    int                   instr_count;
    int                   cycle_count = 0;

    always #CLK_HALF clk = ~clk;

    cpu_front_top u_cpu_front_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .pc_load       (pc_load),
        .pc_load_value (pc_load_value),
        .opcode        (opcode),
        .pc            (pc),
        .rd            (rd),
        .uop           (uop)
    );

    assign exp_entry = REF_TBL[prog_idx[uop.pc]];

    front_checker u_front_checker (
        .clk           (clk),
        .arst_n        (arst_n),
        .pc_load       (pc_load),
        .pc_load_value (pc_load_value),
        .uop           (uop),
        .exp_addr      (exp_entry.uaddr),
        .exp_len       (exp_entry.len),
        .exp_skip      (exp_entry.skip),
        .exp_illegal   (exp_entry.illegal),
        .exp_immed     (exp_entry.opcode[7:0]),
        .error_count   (error_count),
        .instr_count   (instr_count)
    );

    // Read request seen mid-cycle, data returned in the next cycle
    always @(negedge clk) begin
        rd_q    = rd;
        rd_addr = pc;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        arst_n        = 1'b0;
        pc_load       = 1'b0;
        pc_load_value = '0;
        opcode        = '0;
        void'($urandom(32'h3be4));
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_idx[i] = 5'($urandom % REF_ENTRIES);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY arst_n = 1'b1;
        repeat (RUN_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (rd_q) begin
                opcode = REF_TBL[prog_idx[rd_addr]].opcode;
            end
            pc_load       = (($urandom % 40) == 0);   // About one load per 40 cycles
            pc_load_value = 12'($urandom);
        end
        $display("Checked %0d instructions, %0d errors, %0d assertion failures",
                 instr_count, error_count, u_cpu_front_top.u_front_assert.fail_count);
        if (error_count == 0 && u_cpu_front_top.u_front_assert.fail_count == 0
                && instr_count > 0) begin
            $display("Simulation completed successfully");
        end else begin
            if (instr_count == 0) begin
                $display("No instruction was seen on the uop output");
            end
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* bench/front_assert.sv */
`timescale 1ns/100ps
`include "cpu_front_config.svh"

module front_assert (
    input logic                                    clk,
    input logic                                    arst_n,
    input logic                                    flush,
    input logic                                    push,
    input logic                                    pop,
    input logic                                    rd,
    input logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0] level,
    input cpu_front_pkg::uop_t                     uop
);
    localparam int CW = $clog2(`FETCH_QUEUE_DEPTH + 1);

    logic [CW-1:0] held;        // Words pushed since the last flush and not yet popped
    int            fail_count = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held <= '0;
        end else if (flush) begin
            held <= '0;
        end else begin
            held <= held + CW'(push) - CW'(pop);
        end
    end

    push_not_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> (int'(level) < `FETCH_QUEUE_DEPTH))
        else begin
            $error("push into a full fetch queue");
            fail_count++;
        end

    // Stale words are gone from the load cycle on
    pop_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> (!flush && (held != '0)))
        else begin
            $error("pop from an empty fetch queue");
            fail_count++;
        end

    // A routine runs to its last step once started
    valid_held: assert property (@(posedge clk) disable iff (!arst_n)
        (uop.valid && !uop.last) |=> uop.valid)
        else begin
            $error("uop.valid dropped inside a routine");
            fail_count++;
        end

    rd_low_in_reset: assert property (@(posedge clk) !arst_n |-> !rd)
        else begin
            $error("program memory read during reset");
            fail_count++;
        end

endmodule

bind cpu_front_top front_assert u_front_assert (
    .clk    (clk),
    .arst_n (arst_n),
    .flush  (pc_load),
    .push   (push),
    .pop    (pop),
    .rd     (rd),
    .level  (level),
    .uop    (uop)
);

/* bench/front_checker.sv */
`timescale 1ns/100ps
`include "cpu_front_config.svh"

module front_checker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    pc_load,
    input  logic [`PC_WIDTH-1:0]    pc_load_value,
    input  cpu_front_pkg::uop_t     uop,
    input  logic [`UADDR_WIDTH-1:0] exp_addr,     // Reference entry for uop.pc
    input  logic [3:0]              exp_len,
    input  logic                    exp_skip,
    input  logic                    exp_illegal,
    input  logic [7:0]              exp_immed,
    output int                      error_count,
    output int                      instr_count
);
    logic                 in_instr;     // Inside a routine, final step not yet seen
    logic [3:0]           next_step;
    logic [`PC_WIDTH-1:0] cur_pc;
    logic [`PC_WIDTH-1:0] next_pc;      // Program counter model

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    // Sampled mid-cycle, away from the edges
    always @(negedge clk) begin
        if (!arst_n) begin
            in_instr    = 1'b0;
            next_step   = '0;
            cur_pc      = '0;
            next_pc     = '0;           // First fetch comes from address 0
            error_count = 0;
            instr_count = 0;
        end else begin
            if (uop.valid) begin
                if (!in_instr) begin
                    check_field("uop.step", 32'(4'd0), 32'(uop.step));
                    check_field("uop.pc", 32'(next_pc), 32'(uop.pc));
                    cur_pc      = uop.pc;
                    next_pc     = uop.pc + 1'b1;
                    next_step   = '0;
                    in_instr    = 1'b1;
                    instr_count++;
                end else begin
                    check_field("uop.step", 32'(next_step), 32'(uop.step));
                    check_field("uop.pc", 32'(cur_pc), 32'(uop.pc));
                end
                check_field("uop.micro_addr", 32'(exp_addr), 32'(uop.micro_addr));
                check_field("uop.skip_pc_increment", 32'(exp_skip),
                            32'(uop.skip_pc_increment));
                check_field("uop.illegal", 32'(exp_illegal), 32'(uop.illegal));
                check_field("uop.immed", 32'(exp_immed), 32'(uop.immed));
                check_field("uop.last", 32'(next_step == exp_len - 4'd1), 32'(uop.last));
                if (next_step == exp_len - 4'd1) begin
                    in_instr = 1'b0;
                end
                next_step = next_step + 4'd1;
            end else if (in_instr) begin
                error_count++;
                $display("uop.valid dropped before the final step of the routine at pc %h",
                         cur_pc);
                in_instr = 1'b0;
            end
            // Routine starting in the load cycle still came from the old stream
            if (pc_load) begin
                next_pc = pc_load_value;
            end
        end
    end

endmodule

/* hdl/cpu_front_top.sv */
`timescale 1ns/100ps
`include "cpu_front_config.svh"

module cpu_front_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     pc_load,        // Redirect from the datapath
    input  logic [`PC_WIDTH-1:0]     pc_load_value,
    input  logic [`OPCODE_WIDTH-1:0] opcode,         // Program memory read data
    output logic [`PC_WIDTH-1:0]     pc,
    output logic                     rd,
    output cpu_front_pkg::uop_t      uop
);
    localparam int CW = $clog2(`FETCH_QUEUE_DEPTH + 1);

    logic                       push;
    logic                       pop;
    logic                       empty;
    logic [CW-1:0]              level;
    cpu_front_pkg::fetch_word_t wdata;
    cpu_front_pkg::fetch_word_t rdata;

    program_fetch u_program_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .pc_load       (pc_load),
        .pc_load_value (pc_load_value),
        .opcode        (opcode),
        .level         (level),
        .pc            (pc),
        .rd            (rd),
        .push          (push),
        .wdata         (wdata)
    );

    // A load flushes every queued word
    fetch_queue #(
        .payload_t (cpu_front_pkg::fetch_word_t),
        .DEPTH     (`FETCH_QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (pc_load),
        .push   (push),
        .wdata  (wdata),
        .pop    (pop),
        .rdata  (rdata),
        .empty  (empty),
        .level  (level)
    );

    micro_sequencer u_micro_sequencer (
        .clk    (clk),
        .arst_n (arst_n),
        .empty  (empty),
        .rdata  (rdata),
        .pop    (pop),
        .uop    (uop)
    );

endmodule

/* hdl/micro_sequencer.sv */
`timescale 1ns/100ps
`include "cpu_front_config.svh"

module micro_sequencer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       empty,
    input  cpu_front_pkg::fetch_word_t rdata,
    output logic                       pop,
    output cpu_front_pkg::uop_t        uop
);
    logic [`UADDR_WIDTH-1:0]    dec_addr;
    cpu_front_pkg::instr_length dec_len;
    logic                       dec_skip;
    logic                       dec_illegal;
    logic [7:0]                 dec_immed;
    logic [3:0]                 dec_limit;

    logic                       busy;
    logic [3:0]                 step;
    logic [3:0]                 limit;      // Index of the final step
    logic                       last;
    logic [`UADDR_WIDTH-1:0]    addr_q;
    logic                       skip_q;
    logic                       illegal_q;
    logic [7:0]                 immed_q;
    logic [`PC_WIDTH-1:0]       pc_q;

    instr_decode u_instr_decode (
        .opcode            (rdata.opcode),
        .micro_addr        (dec_addr),
        .cycle_length      (dec_len),
        .skip_pc_increment (dec_skip),
        .illegal           (dec_illegal),
        .immed             (dec_immed)
    );

    always_comb begin
        case (dec_len)
            cpu_front_pkg::CYCLE7:  dec_limit = 4'(`LEN_CYCLE7 - 1);
            cpu_front_pkg::CYCLE12: dec_limit = 4'(`LEN_CYCLE12 - 1);
            default:                dec_limit = 4'(`LEN_CYCLE5 - 1);
        endcase
    end

    assign last = busy && (step == limit);
    assign pop  = !empty && (!busy || last);    // Next routine starts with no gap

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            step  <= '0;
            limit <= '0;
        end else if (pop) begin
            busy  <= 1'b1;
            step  <= '0;
            limit <= dec_limit;
        end else if (last) begin
            busy <= 1'b0;                       // Queue ran dry
        end else if (busy) begin
            step <= step + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            addr_q    <= dec_addr;
            skip_q    <= dec_skip;
            illegal_q <= dec_illegal;
            immed_q   <= dec_immed;
            pc_q      <= rdata.pc;
        end
    end

    assign uop = '{
        valid:             busy,
        micro_addr:        addr_q,
        step:              step,
        last:              last,
        skip_pc_increment: skip_q,
        illegal:           illegal_q,
        immed:             immed_q,
        pc:                pc_q
    };

endmodule

/* hdl/instr_decode.sv */
`timescale 1ns/100ps
`include "cpu_front_config.svh"

module instr_decode (
    input  logic [`OPCODE_WIDTH-1:0] opcode,
    output logic [`UADDR_WIDTH-1:0]  micro_addr,
    output cpu_front_pkg::instr_length cycle_length,
    output logic                     skip_pc_increment,
    output logic                     illegal,
    output logic [7:0]               immed
);
    typedef struct packed {
        logic [`UADDR_WIDTH-1:0]    addr;
        cpu_front_pkg::instr_length len;
    } entry_t;

    localparam cpu_front_pkg::instr_length C5  = cpu_front_pkg::CYCLE5;
    localparam cpu_front_pkg::instr_length C7  = cpu_front_pkg::CYCLE7;
    localparam cpu_front_pkg::instr_length C12 = cpu_front_pkg::CYCLE12;
    localparam logic [`UADDR_WIDTH-1:0]    ILLEGAL = `ILLEGAL_UADDR;

    entry_t ent;

    assign micro_addr   = ent.addr;
    assign cycle_length = ent.len;
    assign illegal      = (ent.addr == ILLEGAL);  // No legal routine sits there
    assign immed        = opcode[7:0];

    always_comb begin
        ent               = '{ILLEGAL, C5};       // Table gaps
        skip_pc_increment = 1'b0;
        casez (opcode)
            12'h0??: ent = '{7'd0, C5};           // JP s
            12'h1??: begin                        // RETD e
                ent               = '{7'd1, C12};
                skip_pc_increment = 1'b1;
            end
            12'h2??: ent = '{7'd2, C5};           // JP C, s
            12'h3??: ent = '{7'd3, C5};           // JP NC, s
            12'h4??: begin                        // CALL s
                ent               = '{7'd4, C7};
                skip_pc_increment = 1'b1;
            end
            12'h5??: begin                        // CALZ s
                ent               = '{7'd5, C7};
                skip_pc_increment = 1'b1;
            end
            12'h6??: ent = '{7'd6, C5};           // JP Z, s
            12'h7??: ent = '{7'd7, C5};           // JP NZ, s
            12'h8??: ent = '{7'd8, C5};           // LD Y, e
            12'h9??: ent = '{7'd9, C5};           // LBPX MX, e
            12'hA0?: ent = '{7'd10, C7};          // ADC XH, i
            12'hA1?: ent = '{7'd11, C7};
            12'hA2?: ent = '{7'd12, C7};
            12'hA3?: ent = '{7'd13, C7};
            12'hA4?: ent = '{7'd14, C7};          // CP XH, i
            12'hA5?: ent = '{7'd15, C7};
            12'hA6?: ent = '{7'd16, C7};
            12'hA7?: ent = '{7'd17, C7};
            12'hA8?: ent = '{7'd18, C7};          // ADD r, q
            12'hA9?: ent = '{7'd19, C7};          // ADC r, q
            12'hAA?: ent = '{7'd20, C7};          // SUB r, q
            12'hAB?: ent = '{7'd21, C7};          // SBC r, q
            12'hAC?: ent = '{7'd22, C7};          // AND r, q
            12'hAD?: ent = '{7'd23, C7};          // OR r, q
            12'hAE?: ent = '{7'd24, C7};          // XOR r, q
            12'hAF?: ent = '{7'd25, C7};          // RLC r
            12'hB??: ent = '{7'd26, C5};          // LD X, e
            12'hC??: case (opcode[7:6])           // ALU r, i
                2'b00:   ent = '{7'd27, C7};
                2'b01:   ent = '{7'd28, C7};
                2'b10:   ent = '{7'd29, C7};
                default: ent = '{7'd30, C7};
            endcase
            12'hD??: case (opcode[7:6])           // XOR, SBC, FAN, CP with i
                2'b00:   ent = '{7'd31, C7};
                2'b01:   ent = '{7'd32, C7};
                2'b10:   ent = '{7'd33, C7};
                default: ent = '{7'd34, C7};
            endcase
            12'hE??: casez (opcode[7:0])
                8'b00??_????: ent = '{7'd35, C5}; // LD r, i
                8'b010?_????: ent = '{7'd36, C5}; // PSET p
                8'b0110_????: ent = '{7'd37, C5}; // LDPX MX, i
                8'b0111_????: ent = '{7'd38, C5}; // LDPY MY, i
                8'b1000_00??: ent = '{7'd39, C5};
                8'b1000_01??: ent = '{7'd40, C5};
                8'b1000_10??: ent = '{7'd41, C5};
                8'b1000_11??: ent = '{7'd42, C5}; // RRC r
                8'b1001_00??: ent = '{7'd43, C5};
                8'b1001_01??: ent = '{7'd44, C5};
                8'b1001_10??: ent = '{7'd45, C5};
                8'b1010_00??: ent = '{7'd46, C5}; // LD r, XP
                8'b1010_01??: ent = '{7'd47, C5};
                8'b1010_10??: ent = '{7'd48, C5};
                8'b1011_00??: ent = '{7'd49, C5}; // LD r, YP
                8'b1011_01??: ent = '{7'd50, C5};
                8'b1011_10??: ent = '{7'd51, C5};
                8'b1100_????: ent = '{7'd52, C5}; // LD r, q
                8'b1110_????: ent = '{7'd53, C5}; // LDPX r, q
                8'b1111_????: ent = '{7'd54, C5}; // LDPY r, q
                default:      ;
            endcase
            12'hF0?: ent = '{7'd55, C7};          // CP r, q
            12'hF1?: ent = '{7'd56, C7};          // FAN r, q
            12'hF2?: case (opcode[3:2])
                2'b10:   ent = '{7'd57, C7};      // ACPX MX, r
                2'b11:   ent = '{7'd58, C7};      // ACPY MY, r
                default: ;
            endcase
            12'hF3?: case (opcode[3:2])
                2'b10:   ent = '{7'd59, C7};      // SCPX MX, r
                2'b11:   ent = '{7'd60, C7};      // SCPY MY, r
                default: ;
            endcase
            12'hF4?: ent = '{7'd61, C7};          // SET F, i
            12'hF5?: ent = '{7'd62, C7};          // RST F, i
            12'hF6?: ent = '{7'd63, C7};          // INC Mn
            12'hF7?: ent = '{7'd64, C7};          // DEC Mn
            12'hF8?: ent = '{7'd65, C5};
            12'hF9?: ent = '{7'd66, C5};
            12'hFA?: ent = '{7'd67, C5};
            12'hFB?: ent = '{7'd68, C5};
            12'hFC?: casez (opcode[3:0])          // Stack pushes
                4'b00??: ent = '{7'd69, C5};
                4'b0100: ent = '{7'd70, C5};
                4'b0101: ent = '{7'd71, C5};
                4'b0110: ent = '{7'd72, C5};
                4'b0111: ent = '{7'd73, C5};
                4'b1000: ent = '{7'd74, C5};
                4'b1001: ent = '{7'd75, C5};
                4'b1010: ent = '{7'd76, C5};
                4'b1011: ent = '{7'd77, C5};      // DEC SP
                default: ;
            endcase
            12'hFD?: casez (opcode[3:0])          // Stack pops and returns
                4'b00??: ent = '{7'd78, C5};
                4'b0100: ent = '{7'd79, C5};
                4'b0101: ent = '{7'd80, C5};
                4'b0110: ent = '{7'd81, C5};
                4'b0111: ent = '{7'd82, C5};
                4'b1000: ent = '{7'd83, C5};
                4'b1001: ent = '{7'd84, C5};
                4'b1010: ent = '{7'd85, C5};
                4'b1011: ent = '{7'd86, C5};      // INC SP
                4'b1110: ent = '{7'd87, C12};     // RETS
                4'b1111: begin                    // RET
                    ent               = '{7'd88, C7};
                    skip_pc_increment = 1'b1;
                end
                default: ;
            endcase
            12'hFE?: casez (opcode[3:0])
                4'b00??: ent = '{7'd89, C5};      // LD SPH, r
                4'b01??: ent = '{7'd90, C5};      // LD r, SPH
                4'b1000: ent = '{7'd91, C5};      // JPBA
                default: ;
            endcase
            12'hFF?: casez (opcode[3:0])
                4'b00??: ent = '{7'd92, C5};      // LD SPL, r
                4'b01??: ent = '{7'd93, C5};      // LD r, SPL
                4'b1000: ent = '{7'd94, C5};      // HALT
                4'b1001: ent = '{7'd95, C5};      // SLP
                4'b1011: ent = '{7'd96, C5};      // NOP5
                4'b1111: ent = '{7'd97, C7};      // NOP7
                default: ;
            endcase
            default: ;
        endcase
    end

endmodule

/* hdl/fetch_queue.sv */
`timescale 1ns/100ps
`include "cpu_front_config.svh"

module fetch_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `FETCH_QUEUE_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       push,
    input  payload_t                   wdata,
    input  logic                       pop,
    output payload_t                   rdata,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] level
);
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rdata = mem[rd_ptr];                  // Head shown before the pop
    assign empty = (count == '0) || flush;       // Stale head hidden on flush
    assign level = count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

/* hdl/program_fetch.sv */
`timescale 1ns/100ps
`include "cpu_front_config.svh"

module program_fetch (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    pc_load,
    input  logic [`PC_WIDTH-1:0]                    pc_load_value,
    input  logic [`OPCODE_WIDTH-1:0]                opcode,
    input  logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0] level,
    output logic [`PC_WIDTH-1:0]                    pc,
    output logic                                    rd,
    output logic                                    push,
    output cpu_front_pkg::fetch_word_t              wdata
);
    localparam int CW = $clog2(`FETCH_QUEUE_DEPTH + 1);

    logic                 fetch_en;     // Holds off reads until out of reset
    logic                 pending;      // Read issued last cycle
    logic [`PC_WIDTH-1:0] pending_pc;
    logic [CW:0]          used;         // Queue entries plus read in flight

    assign used  = {1'b0, level} + {{CW{1'b0}}, pending};
    assign rd    = fetch_en && (int'(used) < `FETCH_QUEUE_DEPTH);
    assign push  = pending;             // Opcode arrives one cycle after rd
    assign wdata = '{pc: pending_pc, opcode: opcode};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_en <= 1'b0;
            pending  <= 1'b0;
            pc       <= '0;
        end else begin
            fetch_en <= 1'b1;
            pending  <= rd && !pc_load;  // Discard the read issued with a load
            if (pc_load) begin
                pc <= pc_load_value;
            end else if (rd) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Address tag for the returning opcode
    always_ff @(posedge clk) begin
        if (rd) begin
            pending_pc <= pc;
        end
    end

endmodule

/* hdl/cpu_front_pkg.sv */
`include "cpu_front_config.svh"

package cpu_front_pkg;

    // Length class of a microcode routine
    typedef enum logic [1:0] {
        CYCLE5  = 2'd0,
        CYCLE7  = 2'd1,
        CYCLE12 = 2'd2
    } instr_length;

    // Queue payload, opcode tagged with its address
    typedef struct packed {
        logic [`PC_WIDTH-1:0]     pc;
        logic [`OPCODE_WIDTH-1:0] opcode;
    } fetch_word_t;

    typedef struct packed {
        logic                    valid;
        logic [`UADDR_WIDTH-1:0] micro_addr;
        logic [3:0]              step;               // 0 to length-1
        logic                    last;               // Final step of the routine
        logic                    skip_pc_increment;
        logic                    illegal;
        logic [7:0]              immed;
        logic [`PC_WIDTH-1:0]    pc;
    } uop_t;

endpackage

/* hdl/cpu_front_config.svh */
`ifndef CPU_FRONT_CONFIG_SVH
`define CPU_FRONT_CONFIG_SVH

`define FETCH_QUEUE_DEPTH 4     // Queue entries
`define PC_WIDTH          12
`define OPCODE_WIDTH      12
`define UADDR_WIDTH       7     // Microcode address bits
`define ILLEGAL_UADDR     127   // Reserved routine for undecoded opcodes
`define LEN_CYCLE5        5     // Clocks per length class
`define LEN_CYCLE7        7
`define LEN_CYCLE12       12

`endif
